// File: hdl/rv_pkg.sv
// rv32i core shared definitions
package rv_pkg;

    localparam int xlen          = 32;
    localparam int reg_sel_width = 5;
    localparam int num_regs      = 32;

    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // register ops as {funct7, funct3}
    localparam logic [9:0] fn_add  = 10'b0000000_000;
    localparam logic [9:0] fn_sub  = 10'b0100000_000;
    localparam logic [9:0] fn_sll  = 10'b0000000_001;
    localparam logic [9:0] fn_slt  = 10'b0000000_010;
    localparam logic [9:0] fn_sltu = 10'b0000000_011;
    localparam logic [9:0] fn_xor  = 10'b0000000_100;
    localparam logic [9:0] fn_srl  = 10'b0000000_101;
    localparam logic [9:0] fn_sra  = 10'b0100000_101;
    localparam logic [9:0] fn_or   = 10'b0000000_110;
    localparam logic [9:0] fn_and  = 10'b0000000_111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, five ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        cls_op_imm, cls_load, cls_store, cls_branch,
        cls_op, cls_lui, cls_auipc, cls_illegal
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl,
        alu_sra, alu_slt, alu_sltu, alu_pass_imm, alu_add_pc
    } alu_op_e;

    typedef struct packed {
        op_class_e                op_class;
        alu_op_e                  alu_op;
        logic [reg_sel_width-1:0] rd;
        logic [reg_sel_width-1:0] rs1;
        logic [reg_sel_width-1:0] rs2;
        logic                     is_bne;
        logic [xlen-1:0]          imm;
    } dec_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wr_data;
        logic            rd;
        logic            wr;
    } mem_req_t;

    typedef struct packed {
        logic                     en;
        logic [reg_sel_width-1:0] sel;
        logic [xlen-1:0]          data;
    } rf_wr_t;

endpackage

// File: hdl/rv_decode.sv
// instruction decoder
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::xlen-1:0] instr,
    output rv_pkg::dec_t            dec
);
    import rv_pkg::*;

    instr_u          iw;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;

    assign iw = instr;

    assign imm_i = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
    assign imm_s = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
    // byte offset, bit 0 always clear
    assign imm_b = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                    iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {iw.u_fmt.imm, 12'd0};

    always_comb begin
        dec          = '0;
        dec.op_class = cls_illegal;
        dec.alu_op   = alu_add;
        dec.rd       = iw.r_fmt.rd;
        dec.rs1      = iw.r_fmt.rs1;
        dec.rs2      = iw.r_fmt.rs2;

        case (iw.r_fmt.opcode)
            op_imm: begin
                if (iw.i_fmt.funct3 == f3_addi) begin
                    dec.op_class = cls_op_imm;
                    dec.imm      = imm_i;
                end
            end
            op_load: begin
                dec.op_class = cls_load;
                dec.imm      = imm_i;
            end
            op_store: begin
                dec.op_class = cls_store;
                dec.imm      = imm_s;
            end
            op_branch: begin
                if (iw.b_fmt.funct3 == f3_beq || iw.b_fmt.funct3 == f3_bne) begin
                    dec.op_class = cls_branch;
                    dec.alu_op   = alu_sub;
                    dec.is_bne   = (iw.b_fmt.funct3 == f3_bne);
                    dec.imm      = imm_b;
                end
            end
            op_op: begin
                dec.op_class = cls_op;
                case ({iw.r_fmt.funct7, iw.r_fmt.funct3})
                    fn_add:  dec.alu_op = alu_add;
                    fn_sub:  dec.alu_op = alu_sub;
                    fn_sll:  dec.alu_op = alu_sll;
                    fn_slt:  dec.alu_op = alu_slt;
                    fn_sltu: dec.alu_op = alu_sltu;
                    fn_xor:  dec.alu_op = alu_xor;
                    fn_srl:  dec.alu_op = alu_srl;
                    fn_sra:  dec.alu_op = alu_sra;
                    fn_or:   dec.alu_op = alu_or;
                    fn_and:  dec.alu_op = alu_and;
                    default: dec.op_class = cls_illegal;
                endcase
            end
            op_lui: begin
                dec.op_class = cls_lui;
                dec.alu_op   = alu_pass_imm;
                dec.imm      = imm_u;
            end
            op_auipc: begin
                dec.op_class = cls_auipc;
                dec.alu_op   = alu_add_pc;
                dec.imm      = imm_u;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hdl/rv_regfile.sv
// integer register file
`timescale 1ns/1ps

module rv_regfile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [rv_pkg::reg_sel_width-1:0] rs1_sel,
    input  logic [rv_pkg::reg_sel_width-1:0] rs2_sel,
    input  rv_pkg::rf_wr_t                   rf_wr,
    output logic [rv_pkg::xlen-1:0]          rs1_data,
    output logic [rv_pkg::xlen-1:0]          rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr.en && rf_wr.sel != '0) begin
            // x0 is never written
            regs[rf_wr.sel] <= rf_wr.data;
        end
    end

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rf_wr.en && rf_wr.sel == '0) |=> (regs[0] == '0));

endmodule

// File: hdl/rv_alu.sv
// alu with branch compare
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::dec_t            dec,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;

    // register ops take rs2, everything else the immediate
    assign op_b  = (dec.op_class == cls_op) ? rs2_data : dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:      alu_result = rs1_data + op_b;
            alu_sub:      alu_result = rs1_data - op_b;
            alu_and:      alu_result = rs1_data & op_b;
            alu_or:       alu_result = rs1_data | op_b;
            alu_xor:      alu_result = rs1_data ^ op_b;
            alu_sll:      alu_result = rs1_data << shamt;
            alu_srl:      alu_result = rs1_data >> shamt;
            alu_sra:      alu_result = $signed(rs1_data) >>> shamt;
            alu_slt: begin
                alu_result = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            end
            alu_sltu: begin
                alu_result = {{(xlen-1){1'b0}}, rs1_data < op_b};
            end
            alu_pass_imm: alu_result = dec.imm;
            alu_add_pc:   alu_result = pc + dec.imm;
            default:      alu_result = '0;
        endcase
    end

    // beq or bne
    assign branch_taken = dec.is_bne ? (rs1_data != rs2_data) : (rs1_data == rs2_data);

endmodule

// File: hdl/rv_control.sv
// core control state machine
`timescale 1ns/1ps

module rv_control #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc  = 32'd0,
    parameter logic [rv_pkg::xlen-1:0] out_addr  = 32'd1000,
    parameter logic [rv_pkg::xlen-1:0] halt_addr = 32'd1004
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_ack,
    input  logic [rv_pkg::xlen-1:0] mem_rd_data,
    input  rv_pkg::dec_t            dec,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic                    branch_taken,
    output rv_pkg::mem_req_t        mem_req,
    output rv_pkg::rf_wr_t          rf_wr,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] out_data,
    output logic                    out_valid,
    output logic                    halt
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        st_fetch, st_exec, st_mem, st_halted
    } state_e;

    state_e                   state;
    state_e                   next_state;
    logic [xlen-1:0]          next_pc;
    logic                     issue_fetch;
    logic                     halt_now;
    // pending data access
    logic [reg_sel_width-1:0] pend_rd;
    logic                     pend_load;
    logic [reg_sel_width-1:0] next_pend_rd;
    logic                     next_pend_load;

    always_comb begin
        next_state     = state;
        next_pc        = pc;
        issue_fetch    = 1'b0;
        halt_now       = 1'b0;
        next_pend_rd   = pend_rd;
        next_pend_load = pend_load;
        mem_req        = '0;
        rf_wr          = '0;
        out_data       = '0;
        out_valid      = 1'b0;

        case (state)
            st_fetch: begin
                // no fetch while reset is held
                issue_fetch = !rst;
            end
            st_exec: begin
                // the fetched instruction runs in its ack cycle
                if (mem_ack) begin
                    next_pc = pc + 32'd4;
                    case (dec.op_class)
                        cls_op_imm, cls_op, cls_lui, cls_auipc: begin
                            rf_wr.en    = 1'b1;
                            rf_wr.sel   = dec.rd;
                            rf_wr.data  = alu_result;
                            issue_fetch = 1'b1;
                        end
                        cls_branch: begin
                            if (branch_taken) begin
                                next_pc = pc + dec.imm;
                            end
                            issue_fetch = 1'b1;
                        end
                        cls_load: begin
                            mem_req.rd     = 1'b1;
                            mem_req.addr   = alu_result;
                            next_pend_rd   = dec.rd;
                            next_pend_load = 1'b1;
                            next_state     = st_mem;
                        end
                        cls_store: begin
                            if (alu_result == out_addr) begin
                                out_valid   = 1'b1;
                                out_data    = rs2_data;
                                issue_fetch = 1'b1;
                            end else if (alu_result == halt_addr) begin
                                halt_now   = 1'b1;
                                next_state = st_halted;
                            end else begin
                                mem_req.wr      = 1'b1;
                                mem_req.addr    = alu_result;
                                mem_req.wr_data = rs2_data;
                                next_pend_load  = 1'b0;
                                next_state      = st_mem;
                            end
                        end
                        default: begin
                            // illegal opcode stops the core
                            halt_now   = 1'b1;
                            next_state = st_halted;
                        end
                    endcase
                end
            end
            st_mem: begin
                // pc already points past the load or store
                if (mem_ack) begin
                    if (pend_load) begin
                        rf_wr.en   = 1'b1;
                        rf_wr.sel  = pend_rd;
                        rf_wr.data = mem_rd_data;
                    end
                    issue_fetch = 1'b1;
                end
            end
            default: begin
            end
        endcase

        if (issue_fetch) begin
            mem_req.rd   = 1'b1;
            mem_req.addr = next_pc;
            next_state   = st_exec;
        end
    end

    assign halt = halt_now || (state == st_halted);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_fetch;
            pc        <= reset_pc;
            pend_rd   <= '0;
            pend_load <= 1'b0;
        end else begin
            state     <= next_state;
            pc        <= next_pc;
            pend_rd   <= next_pend_rd;
            pend_load <= next_pend_load;
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd && mem_req.wr));

    a_halted_quiet: assert property (@(posedge clk) disable iff (rst)
        halt |=> (halt && !mem_req.rd && !mem_req.wr));

    // effective address from the alu matches base plus offset
    a_eff_addr: assert property (@(posedge clk) disable iff (rst)
        (state == st_exec && mem_ack &&
         (dec.op_class == cls_load || dec.op_class == cls_store))
        |-> (alu_result == rs1_data + dec.imm));

endmodule

// File: hdl/rv_core.sv
// rv32i multicycle core
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc  = 32'd0,
    parameter logic [rv_pkg::xlen-1:0] out_addr  = 32'd1000,
    parameter logic [rv_pkg::xlen-1:0] halt_addr = 32'd1004
) (
    input  logic                    clk,
    input  logic                    rst,
    output rv_pkg::mem_req_t        mem_req,
    input  logic [rv_pkg::xlen-1:0] mem_rd_data,
    input  logic                    mem_ack,
    output logic [rv_pkg::xlen-1:0] out_data,
    output logic                    out_valid,
    output logic                    halt
);
    import rv_pkg::*;

    dec_t            dec;
    rf_wr_t          rf_wr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic            branch_taken;

    rv_control #(
        .reset_pc  (reset_pc),
        .out_addr  (out_addr),
        .halt_addr (halt_addr)
    ) u_control (
        .clk          (clk),
        .rst          (rst),
        .mem_ack      (mem_ack),
        .mem_rd_data  (mem_rd_data),
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .mem_req      (mem_req),
        .rf_wr        (rf_wr),
        .pc           (pc),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .halt         (halt)
    );

    // the fetched word is decoded straight off the read bus
    rv_decode u_decode (
        .instr (mem_rd_data),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec.rs1),
        .rs2_sel  (dec.rs2),
        .rf_wr    (rf_wr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .dec          (dec),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

endmodule

// File: dv/rv_tb_mem.sv
// behavioral word memory
`timescale 1ns/1ps

module rv_tb_mem #(
    parameter int words = 512
) (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::mem_req_t        mem_req,
    output logic [rv_pkg::xlen-1:0] mem_rd_data,
    output logic                    mem_ack
);
    import rv_pkg::*;

    localparam int aw = $clog2(words);

    logic [xlen-1:0] mem [words];
    mem_req_t        held;
    int              taken;
    int              served;
    int              wait_left;
    int unsigned     seed_draw;

    initial begin
        seed_draw   = $urandom(91);
        mem_ack     = 1'b0;
        mem_rd_data = '0;
    end

    // requests are strobes, latched at the rising edge
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            taken <= 0;
        end else if (mem_req.rd || mem_req.wr) begin
            held  <= mem_req;
            taken <= taken + 1;
        end
    end

    // ack after 1 to 4 cycles, driven on the falling edge
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            served    = 0;
            wait_left = 0;
        end else begin
            mem_ack <= 1'b0;
            if (served != taken) begin
                if (wait_left == 0) begin
                    wait_left = $urandom_range(4, 1);
                end
                wait_left = wait_left - 1;
                if (wait_left == 0) begin
                    served = served + 1;
                    mem_ack <= 1'b1;
                    if (held.wr) begin
                        mem[held.addr[aw+1:2]] = held.wr_data;
                    end else begin
                        mem_rd_data <= mem[held.addr[aw+1:2]];
                    end
                end
            end
        end
    end

    task automatic fill_pattern();
        for (int i = 0; i < words; i++) begin
            mem[i] = 32'(i * 4) ^ 32'ha5a5_0000;
        end
    endtask

    task automatic load_word(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        mem[addr[aw+1:2]] = data;
    endtask

    function automatic logic [xlen-1:0] peek_word(input logic [xlen-1:0] addr);
        return mem[addr[aw+1:2]];
    endfunction

endmodule

// File: dv/tb_rv_core.sv
// rv32i core testbench
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam logic [31:0] reset_pc  = 32'd0;
    localparam logic [31:0] out_addr  = 32'd1000;
    localparam logic [31:0] halt_addr = 32'd1004;
    localparam int          run_limit = 2000;

    logic            clk;
    logic            rst;
    mem_req_t        mem_req;
    logic [xlen-1:0] mem_rd_data;
    logic            mem_ack;
    logic [xlen-1:0] out_data;
    logic            out_valid;
    logic            halt;

    logic [xlen-1:0] prog [$];
    logic [xlen-1:0] outs [$];
    logic [xlen-1:0] expect_q [$];
    int              errors;
    int              timeouts;
    int              checks;

    rv_core #(
        .reset_pc  (reset_pc),
        .out_addr  (out_addr),
        .halt_addr (halt_addr)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    rv_tb_mem u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] r_word(input logic [9:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        instr_u w;
        w = '0;
        w.r_fmt.opcode = op_op;
        w.r_fmt.funct7 = fn[9:3];
        w.r_fmt.funct3 = fn[2:0];
        w.r_fmt.rd     = rd;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.rs2    = rs2;
        return w;
    endfunction

    function automatic logic [31:0] imm_word(input logic [6:0] opcode, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input int imm);
        instr_u w;
        w = '0;
        w.i_fmt.opcode = opcode;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.imm    = imm[11:0];
        return w;
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input int off);
        instr_u w;
        w = '0;
        w.s_fmt.opcode = op_store;
        w.s_fmt.funct3 = 3'b010;
        w.s_fmt.rs1    = rs1;
        w.s_fmt.rs2    = rs2;
        w.s_fmt.imm_hi = off[11:5];
        w.s_fmt.imm_lo = off[4:0];
        return w;
    endfunction

    function automatic logic [31:0] br_word(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input int off);
        instr_u w;
        w = '0;
        w.b_fmt.opcode   = op_branch;
        w.b_fmt.funct3   = f3;
        w.b_fmt.rs1      = rs1;
        w.b_fmt.rs2      = rs2;
        w.b_fmt.imm_12   = off[12];
        w.b_fmt.imm_11   = off[11];
        w.b_fmt.imm_10_5 = off[10:5];
        w.b_fmt.imm_4_1  = off[4:1];
        return w;
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] opcode, input logic [4:0] rd,
                                               input logic [19:0] imm);
        instr_u w;
        w = '0;
        w.u_fmt.opcode = opcode;
        w.u_fmt.rd     = rd;
        w.u_fmt.imm    = imm;
        return w;
    endfunction

    // expected register op results, written from the instruction set rules
    function automatic logic [31:0] model_alu(input logic [9:0] fn, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (fn)
            fn_add:  return a + b;
            fn_sub:  return a + ~b + 32'd1;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_xor:  return a ^ b;
            fn_sll:  return a << s;
            fn_srl:  return a >> s;
            fn_sra:  return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'd0);
            fn_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            fn_sltu: return {31'd0, a < b};
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] next_addr();
        return reset_pc + 32'(prog.size() * 4);
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic li(input logic [4:0] rd, input int val);
        emit(imm_word(op_imm, f3_addi, rd, 5'd0, val));
    endtask

    task automatic show(input logic [4:0] rs);
        emit(sw_word(5'd0, rs, int'(out_addr)));
    endtask

    task automatic stop();
        emit(sw_word(5'd0, 5'd0, int'(halt_addr)));
    endtask

    task automatic new_program();
        prog.delete();
        expect_q.delete();
    endtask

    task automatic apply_reset(input string name);
        int          n;
        bit          seen;
        logic        first_rd;
        logic [31:0] first_addr;
        @(negedge clk);
        rst = 1'b1;
        for (n = 0; n < 16; n++) begin
            @(negedge clk);
            checks++;
            if (halt || out_valid || mem_req.rd || mem_req.wr) begin
                $display("%s: halt, out_valid or a memory request high while in reset",
                         name);
                errors++;
            end
        end
        rst  = 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 20) begin
            @(posedge clk);
            if (halt || out_valid) begin
                $display("%s: halt or out_valid high before the first fetch", name);
                errors++;
            end
            if (mem_req.rd || mem_req.wr) begin
                seen       = 1'b1;
                first_rd   = mem_req.rd;
                first_addr = mem_req.addr;
            end
            n++;
        end
        checks++;
        if (!seen) begin
            $display("%s: no memory request after reset release", name);
            timeouts++;
        end else if (!first_rd || first_addr !== reset_pc) begin
            $display("** Error [%s] first request: expected read at %h, actual rd=%b addr=%h",
                     name, reset_pc, first_rd, first_addr);
            errors++;
        end
    endtask

    // load the program, reset, and gather outputs until halt
    task automatic run_program(input string name);
        int n;
        bit done;
        u_mem.fill_pattern();
        foreach (prog[i]) begin
            u_mem.load_word(reset_pc + 32'(i * 4), prog[i]);
        end
        apply_reset(name);
        outs.delete();
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (out_valid) begin
                outs.push_back(out_data);
            end
            if (halt) begin
                done = 1'b1;
            end else if (n >= run_limit) begin
                $display("%s: core did not halt within %0d cycles", name, run_limit);
                timeouts++;
                done = 1'b1;
            end
            n++;
        end
    endtask

    task automatic check_outputs(input string name);
        checks++;
        if (outs.size() != expect_q.size()) begin
            $display("** Error [%s] output count: expected %0d, actual %0d",
                     name, expect_q.size(), outs.size());
            errors++;
        end
        foreach (expect_q[i]) begin
            if (i < outs.size()) begin
                checks++;
                if (outs[i] !== expect_q[i]) begin
                    $display("** Error [%s] output %0d: expected %h, actual %h",
                             name, i, expect_q[i], outs[i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic check_mem(input string name, input logic [31:0] addr,
                             input logic [31:0] value);
        logic [31:0] got;
        got = u_mem.peek_word(addr);
        checks++;
        if (got !== value) begin
            $display("** Error [%s] memory at %h: expected %h, actual %h",
                     name, addr, value, got);
            errors++;
        end
    endtask

    task automatic watch_halted(input string name, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            checks++;
            if (!halt) begin
                $display("%s: halt dropped after the core stopped", name);
                errors++;
            end
            if (out_valid || mem_req.rd || mem_req.wr) begin
                $display("%s: output or memory activity after halt", name);
                errors++;
            end
        end
    endtask

    task automatic test_reset();
        new_program();
        li(1, 5);
        show(1);
        expect_q.push_back(32'd5);
        stop();
        run_program("reset");
        check_outputs("reset");
    endtask

    task automatic test_alu();
        logic [9:0] fns [10];
        int         a_vals [3];
        int         b_vals [3];
        fns = '{fn_add, fn_sub, fn_and, fn_or, fn_xor,
                fn_sll, fn_srl, fn_sra, fn_slt, fn_sltu};
        a_vals = '{-7, 1234, 0};
        b_vals = '{5, -3, 0};
        a_vals[2] = int'($urandom_range(4095, 0)) - 2048;
        b_vals[2] = int'($urandom_range(4095, 0)) - 2048;
        new_program();
        foreach (a_vals[p]) begin
            li(1, a_vals[p]);
            li(2, b_vals[p]);
            show(1);
            expect_q.push_back(32'(a_vals[p]));
            foreach (fns[k]) begin
                emit(r_word(fns[k], 5'd10, 5'd1, 5'd2));
                show(10);
                expect_q.push_back(model_alu(fns[k], a_vals[p], b_vals[p]));
            end
        end
        stop();
        run_program("alu");
        check_outputs("alu");
    endtask

    task automatic test_upper();
        logic [31:0] at;
        new_program();
        emit(upper_word(op_lui, 5'd5, 20'h12345));
        show(5);
        expect_q.push_back(32'h1234_5000);
        at = next_addr();
        emit(upper_word(op_auipc, 5'd6, 20'habcde));
        show(6);
        expect_q.push_back(32'habcd_e000 + at);
        stop();
        run_program("lui_auipc");
        check_outputs("lui_auipc");
    endtask

    task automatic test_memory();
        new_program();
        li(1, 291);
        li(2, -2);
        li(3, 512);
        emit(sw_word(5'd3, 5'd1, 0));
        emit(sw_word(5'd3, 5'd2, 4));
        emit(imm_word(op_load, 3'b010, 5'd4, 5'd3, 0));
        emit(imm_word(op_load, 3'b010, 5'd5, 5'd3, 4));
        show(4);
        show(5);
        // both writes to x0 must be lost
        emit(imm_word(op_imm, f3_addi, 5'd0, 5'd1, 0));
        emit(imm_word(op_load, 3'b010, 5'd0, 5'd3, 0));
        show(0);
        stop();
        expect_q.push_back(32'd291);
        expect_q.push_back(32'hffff_fffe);
        expect_q.push_back(32'd0);
        run_program("memory");
        check_outputs("memory");
        check_mem("memory", 32'd512, 32'd291);
        check_mem("memory", 32'd516, 32'hffff_fffe);
    endtask

    task automatic test_branch();
        logic [31:0] loop_at;
        new_program();
        li(1, 5);
        loop_at = next_addr();
        show(1);
        emit(imm_word(op_imm, f3_addi, 5'd1, 5'd1, -1));
        emit(br_word(f3_bne, 5'd1, 5'd0, int'(loop_at) - int'(next_addr())));
        for (int i = 5; i > 0; i--) begin
            expect_q.push_back(32'(i));
        end
        li(2, 1);
        emit(br_word(f3_beq, 5'd2, 5'd0, 8));
        show(2);
        expect_q.push_back(32'd1);
        li(8, 88);
        // taken beq jumps over a halt
        emit(br_word(f3_beq, 5'd0, 5'd0, 8));
        stop();
        show(8);
        expect_q.push_back(32'd88);
        emit(br_word(f3_bne, 5'd8, 5'd8, 8));
        show(8);
        expect_q.push_back(32'd88);
        stop();
        run_program("branch");
        check_outputs("branch");
    endtask

    task automatic test_halt();
        logic [31:0] bad [2];
        bad[0] = 32'h0000_0000;
        bad[1] = r_word(10'b0000001_000, 5'd3, 5'd1, 5'd1);
        new_program();
        li(1, 9);
        show(1);
        stop();
        show(1);
        expect_q.push_back(32'd9);
        run_program("halt_store");
        check_outputs("halt_store");
        watch_halted("halt_store", 40);
        foreach (bad[p]) begin
            new_program();
            li(1, 3);
            show(1);
            emit(bad[p]);
            show(1);
            stop();
            expect_q.push_back(32'd3);
            run_program("illegal");
            check_outputs("illegal");
            watch_halted("illegal", 40);
        end
    endtask

    initial begin
        rst      = 1'b1;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        test_reset();
        test_alu();
        test_upper();
        test_memory();
        test_branch();
        test_halt();
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_control.sv
hdl/rv_core.sv
dv/rv_tb_mem.sv
dv/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/rv_decode.sv
      - hdl/rv_regfile.sv
      - hdl/rv_alu.sv
      - hdl/rv_control.sv
      - hdl/rv_core.sv
  - target: test
    files:
      - dv/rv_tb_mem.sv
      - dv/tb_rv_core.sv
